//--- logic/aplic_cfg.svh
/*
 * Sizing and reset constants for the APLIC register-control core.
 * Included by every file that sizes a port, an array or a reset value.
 */
`ifndef APLIC_CFG_SVH
`define APLIC_CFG_SVH

// Source slots, slot 0 exists but is never a real source
`define APLIC_NR_SRC 32

// Machine domain is 0, supervisor domain is 1
`define APLIC_NR_DOM 2

// Width of a source index
`define APLIC_SRC_W 5

// Byte offset inside one domain window
`define APLIC_ADDR_W 16

// domaincfg after reset, only the fixed 0x80 top byte is set
`define APLIC_DOMCFG_RST 32'h8000_0000

`endif

//--- logic/aplic_map_pkg.sv
/*
 * Register map of one APLIC domain window. Holds the register kinds
 * that the decoder hands to the blocks and the bank selector for the IP/IE banks.
 */
`include "aplic_cfg.svh"

package aplic_map_pkg;

  typedef enum logic [3:0] {
    NONE, DOMCFG, SRCCFG, SETIP, SETIPNUM, INCLRIP, CLRIPNUM,
    SETIE, SETIENUM, CLRIE, CLRIENUM, TARGET
  } aplic_reg_e;

  typedef enum logic {
    PENDING,
    ENABLE
  } aplic_bank_e;

  // Byte offsets, sourcecfg and target are windows of 32 words
  localparam logic [`APLIC_ADDR_W-1:0] OFF_DOMCFG   = 16'h0000;
  localparam logic [`APLIC_ADDR_W-1:0] OFF_SRCCFG   = 16'h0000;
  localparam logic [`APLIC_ADDR_W-1:0] OFF_SETIP    = 16'h1C00;
  localparam logic [`APLIC_ADDR_W-1:0] OFF_SETIPNUM = 16'h1CDC;
  localparam logic [`APLIC_ADDR_W-1:0] OFF_INCLRIP  = 16'h1D00;
  localparam logic [`APLIC_ADDR_W-1:0] OFF_CLRIPNUM = 16'h1DDC;
  localparam logic [`APLIC_ADDR_W-1:0] OFF_SETIE    = 16'h1E00;
  localparam logic [`APLIC_ADDR_W-1:0] OFF_SETIENUM = 16'h1EDC;
  localparam logic [`APLIC_ADDR_W-1:0] OFF_CLRIE    = 16'h1F00;
  localparam logic [`APLIC_ADDR_W-1:0] OFF_CLRIENUM = 16'h1FDC;
  localparam logic [`APLIC_ADDR_W-1:0] OFF_TARGET   = 16'h3000;

endpackage

//--- logic/aplic_intr_pkg.sv
/*
 * Field layouts of the interrupt registers: domaincfg bits, source modes
 * and the target word, which reads differently in direct and MSI delivery.
 */
package aplic_intr_pkg;

  // domaincfg fields
  localparam int DOMCFG_IE_BIT = 8;
  localparam int DOMCFG_DM_BIT = 2;

  // sourcecfg delegate bit, M sees only this bit for a delegated source
  localparam int SRCCFG_D_BIT = 10;

  typedef enum logic [2:0] {
    INACTIVE = 3'd0,
    DETACHED = 3'd1,
    EDGE1    = 3'd4,
    EDGE0    = 3'd5,
    LEVEL1   = 3'd6,
    LEVEL0   = 3'd7
  } src_mode_e;

  // One stored target word, the domain's DM bit picks the view
  typedef union packed {
    struct packed {
      logic [13:0] hart;
      logic [9:0]  rsvd;
      logic [7:0]  prio;
    } direct;
    struct packed {
      logic [13:0] hart;
      logic [5:0]  guest;
      logic        rsvd;
      logic [10:0] eiid;
    } msi;
  } target_word_u;

endpackage

//--- logic/aplic_wr_if.sv
/*
 * Decoded register access, driven by the decoder and seen by every register
 * block. Kind and index are valid for reads too, wr_en marks a write.
 */
`timescale 1ns/100ps
`include "aplic_cfg.svh"

interface aplic_wr_if import aplic_map_pkg::*; ();

  logic                             wr_en;
  logic [$clog2(`APLIC_NR_DOM)-1:0] dom;
  aplic_reg_e                       kind;
  logic [`APLIC_SRC_W-1:0]          idx;
  logic [31:0]                      wdata;

  modport decoder (
    output wr_en, dom, kind, idx, wdata
  );

  modport block (
    input wr_en, dom, kind, idx, wdata
  );

endinterface

//--- logic/aplic_reg_decode.sv
/*
 * Address decoder and read mux. Turns one access into a register kind and
 * source index for the blocks, and picks the read word of the owning block.
 */
`timescale 1ns/100ps
`include "aplic_cfg.svh"

module aplic_reg_decode import aplic_map_pkg::*; (
  input  logic                             i_acc_en,
  input  logic                             i_acc_we,
  input  logic [$clog2(`APLIC_NR_DOM)-1:0] i_acc_dom,
  input  logic [`APLIC_ADDR_W-1:0]         i_acc_addr,
  input  logic [31:0]                      i_acc_wdata,
  output logic [31:0]                      o_acc_rdata,
  aplic_wr_if.decoder                      wr,
  input  logic [31:0]                      i_dom_rdata,
  input  logic [31:0]                      i_pend_rdata,
  input  logic [31:0]                      i_en_rdata,
  input  logic [31:0]                      i_tgt_rdata
);

  localparam int WIN_LSB = `APLIC_SRC_W + 2;

  aplic_reg_e              kind;
  logic [`APLIC_SRC_W-1:0] idx;
  logic [`APLIC_SRC_W-1:0] slot;
  logic                    aligned;
  logic [31:0]             rd_sel;

  assign slot    = i_acc_addr[WIN_LSB-1:2];
  assign aligned = (i_acc_addr[1:0] == 2'b00);

  // ==========================================================================
  // Offset decode
  // ==========================================================================
  always_comb begin
    kind = NONE;
    idx  = '0;
    case (i_acc_addr)
      OFF_DOMCFG:   kind = DOMCFG;
      OFF_SETIP:    kind = SETIP;
      OFF_SETIPNUM: kind = SETIPNUM;
      OFF_INCLRIP:  kind = INCLRIP;
      OFF_CLRIPNUM: kind = CLRIPNUM;
      OFF_SETIE:    kind = SETIE;
      OFF_SETIENUM: kind = SETIENUM;
      OFF_CLRIE:    kind = CLRIE;
      OFF_CLRIENUM: kind = CLRIENUM;
      default: begin
        // Slot 0 of either window is not a source
        if (aligned && slot != '0) begin
          if (i_acc_addr[`APLIC_ADDR_W-1:WIN_LSB] == OFF_SRCCFG[`APLIC_ADDR_W-1:WIN_LSB]) begin
            kind = SRCCFG;
            idx  = slot;
          end else if (i_acc_addr[`APLIC_ADDR_W-1:WIN_LSB] ==
                       OFF_TARGET[`APLIC_ADDR_W-1:WIN_LSB]) begin
            kind = TARGET;
            idx  = slot;
          end
        end
      end
    endcase
  end

  assign wr.wr_en = i_acc_en && i_acc_we && (kind != NONE);
  assign wr.dom   = i_acc_dom;
  assign wr.kind  = kind;
  assign wr.idx   = idx;
  assign wr.wdata = i_acc_wdata;

  // ==========================================================================
  // Read select
  // ==========================================================================
  // Number registers, in_clrip and clrie always read as zero
  always_comb begin
    case (kind)
      DOMCFG, SRCCFG: rd_sel = i_dom_rdata;
      SETIP:          rd_sel = i_pend_rdata;
      SETIE:          rd_sel = i_en_rdata;
      TARGET:         rd_sel = i_tgt_rdata;
      default:        rd_sel = '0;
    endcase
  end

  assign o_acc_rdata = (i_acc_en && !i_acc_we) ? rd_sel : '0;

endmodule

//--- logic/aplic_domain_ctl.sv
/*
 * Per-domain domaincfg and the shared sourcecfg array. Tracks which domain
 * owns each source and publishes ownership, the active vector and IE/DM.
 */
`timescale 1ns/100ps
`include "aplic_cfg.svh"

module aplic_domain_ctl import aplic_map_pkg::*, aplic_intr_pkg::*; (
  input  logic                     i_clk,
  input  logic                     ni_rst,
  aplic_wr_if.block                wr,
  output logic [31:0]              o_rdata,
  output logic [`APLIC_NR_SRC-1:0] o_intp_domain,
  output logic [`APLIC_NR_SRC-1:0] o_active,
  output logic [`APLIC_NR_DOM-1:0] o_domaincfg_ie,
  output logic [`APLIC_NR_DOM-1:0] o_domaincfg_dm
);

  logic [`APLIC_NR_DOM-1:0] ie_q;
  logic [`APLIC_NR_DOM-1:0] dm_q;
  // Owner per source, 0 is M and 1 is S
  logic [`APLIC_NR_SRC-1:1] owner_q;
  src_mode_e                mode_q [1:`APLIC_NR_SRC-1];
  src_mode_e                wr_mode;
  logic                     wr_deleg;

  // Modes 2 and 3 are reserved
  always_comb begin
    wr_deleg = wr.wdata[SRCCFG_D_BIT];
    if (wr.wdata[2:1] == 2'b01) begin
      wr_mode = INACTIVE;
    end else begin
      wr_mode = src_mode_e'(wr.wdata[2:0]);
    end
  end

  // ==========================================================================
  // Register updates
  // ==========================================================================
  always_ff @(posedge i_clk or negedge ni_rst) begin
    if (!ni_rst) begin
      ie_q    <= '0;
      dm_q    <= '0;
      owner_q <= '0;
      for (int i = 1; i < `APLIC_NR_SRC; i++) begin
        mode_q[i] <= INACTIVE;
      end
    end else if (wr.wr_en) begin
      if (wr.kind == DOMCFG) begin
        ie_q[wr.dom] <= wr.wdata[DOMCFG_IE_BIT];
        dm_q[wr.dom] <= wr.wdata[DOMCFG_DM_BIT];
      end
      if (wr.kind == SRCCFG) begin
        if (wr.dom == '0) begin
          // M can move the source to S or pull it back
          owner_q[wr.idx] <= wr_deleg;
          mode_q[wr.idx]  <= wr_deleg ? INACTIVE : wr_mode;
        end else if (owner_q[wr.idx]) begin
          // S cannot delegate further
          mode_q[wr.idx] <= wr_deleg ? INACTIVE : wr_mode;
        end
      end
    end
  end

  // ==========================================================================
  // Read word and status
  // ==========================================================================
  always_comb begin
    o_rdata = '0;
    case (wr.kind)
      DOMCFG: begin
        o_rdata = `APLIC_DOMCFG_RST;
        o_rdata[DOMCFG_IE_BIT] = ie_q[wr.dom];
        o_rdata[DOMCFG_DM_BIT] = dm_q[wr.dom];
      end
      SRCCFG: begin
        if (owner_q[wr.idx] == wr.dom) begin
          o_rdata = {29'b0, mode_q[wr.idx]};
        end else if (wr.dom == '0) begin
          o_rdata[SRCCFG_D_BIT] = 1'b1;
        end
      end
      default: o_rdata = '0;
    endcase
  end

  always_comb begin
    o_active = '0;
    for (int i = 1; i < `APLIC_NR_SRC; i++) begin
      o_active[i] = (mode_q[i] != INACTIVE);
    end
  end

  assign o_intp_domain  = {owner_q, 1'b0};
  assign o_domaincfg_ie = ie_q;
  assign o_domaincfg_dm = dm_q;

endmodule

//--- logic/aplic_ix_bank.sv
/*
 * One 32-bit interrupt bit bank, instantiated once for pending and once
 * for enable. Word and number set/clear, limited to the writer's own sources.
 */
`timescale 1ns/100ps
`include "aplic_cfg.svh"

module aplic_ix_bank import aplic_map_pkg::*; #(
  parameter aplic_bank_e P_BANK = PENDING
) (
  input  logic                     i_clk,
  input  logic                     ni_rst,
  aplic_wr_if.block                wr,
  input  logic [`APLIC_NR_SRC-1:0] i_intp_domain,
  input  logic [`APLIC_NR_SRC-1:0] i_active,
  output logic [31:0]              o_rdata,
  output logic [`APLIC_NR_SRC-1:0] o_bits
);

  // The four register kinds of this bank
  localparam aplic_reg_e K_SET    = aplic_reg_e'((P_BANK == PENDING) ? SETIP : SETIE);
  localparam aplic_reg_e K_SETNUM = aplic_reg_e'((P_BANK == PENDING) ? SETIPNUM : SETIENUM);
  localparam aplic_reg_e K_CLR    = aplic_reg_e'((P_BANK == PENDING) ? INCLRIP : CLRIE);
  localparam aplic_reg_e K_CLRNUM = aplic_reg_e'((P_BANK == PENDING) ? CLRIPNUM : CLRIENUM);

  logic [`APLIC_NR_SRC-1:0] bits_q;
  logic [`APLIC_NR_SRC-1:0] bits_d;
  logic [`APLIC_NR_SRC-1:0] own;
  logic [`APLIC_SRC_W-1:0]  num;
  logic                     num_ok;

  // Sources owned by the accessing domain, slot 0 never
  assign own = (wr.dom == '0) ? {~i_intp_domain[`APLIC_NR_SRC-1:1], 1'b0} : i_intp_domain;

  assign num    = wr.wdata[`APLIC_SRC_W-1:0];
  assign num_ok = (wr.wdata[31:`APLIC_SRC_W] == '0) && own[num];

  always_comb begin
    bits_d = bits_q;
    if (wr.wr_en) begin
      case (wr.kind)
        K_SET:    bits_d = (bits_q & ~own) | (wr.wdata & own);
        K_CLR:    bits_d = bits_q & ~(wr.wdata & own);
        K_SETNUM: begin
          if (num_ok) begin
            bits_d[num] = 1'b1;
          end
        end
        K_CLRNUM: begin
          if (num_ok) begin
            bits_d[num] = 1'b0;
          end
        end
        default:  bits_d = bits_q;
      endcase
    end
  end

  // Inactive sources drop their bit on every edge
  always_ff @(posedge i_clk or negedge ni_rst) begin
    if (!ni_rst) begin
      bits_q <= '0;
    end else begin
      bits_q <= {bits_d[`APLIC_NR_SRC-1:1] & i_active[`APLIC_NR_SRC-1:1], 1'b0};
    end
  end

  assign o_rdata = (wr.kind == K_SET) ? (bits_q & own) : '0;
  assign o_bits  = bits_q;

endmodule

//--- logic/aplic_target.sv
/*
 * target registers for sources 1 to 31. The written word is legalized by
 * the delivery mode of the writing domain, direct or MSI.
 */
`timescale 1ns/100ps
`include "aplic_cfg.svh"

module aplic_target import aplic_map_pkg::*, aplic_intr_pkg::*; (
  input  logic                     i_clk,
  input  logic                     ni_rst,
  aplic_wr_if.block                wr,
  input  logic [`APLIC_NR_SRC-1:0] i_intp_domain,
  input  logic [`APLIC_NR_SRC-1:0] i_active,
  input  logic [`APLIC_NR_DOM-1:0] i_dm,
  output logic [31:0]              o_rdata
);

  target_word_u tgt_q [1:`APLIC_NR_SRC-1];
  target_word_u w_leg;
  logic         owned;
  logic         tgt_we;

  assign owned  = (i_intp_domain[wr.idx] == wr.dom);
  assign tgt_we = wr.wr_en && (wr.kind == TARGET) && i_active[wr.idx] && owned;

  always_comb begin
    w_leg = target_word_u'(wr.wdata);
    if (!i_dm[wr.dom]) begin
      // Direct delivery, priority 0 is not allowed
      w_leg.direct.rsvd = '0;
      if (w_leg.direct.prio == '0) begin
        w_leg.direct.prio = 8'd1;
      end
    end else begin
      w_leg.msi.rsvd = 1'b0;
    end
  end

  always_ff @(posedge i_clk or negedge ni_rst) begin
    if (!ni_rst) begin
      for (int i = 1; i < `APLIC_NR_SRC; i++) begin
        tgt_q[i] <= '0;
      end
    end else if (tgt_we) begin
      tgt_q[wr.idx] <= w_leg;
    end
  end

  assign o_rdata = (wr.kind == TARGET && owned) ? tgt_q[wr.idx] : '0;

endmodule

//--- logic/aplic_regctl_top.sv
/*
 * Register-control core of a two-domain APLIC. One plain access port with
 * a domain select, plus the pending, enable and ownership status vectors.
 */
`timescale 1ns/100ps
`include "aplic_cfg.svh"

module aplic_regctl_top import aplic_map_pkg::*; (
  input  logic                             i_clk,
  input  logic                             ni_rst,
  input  logic                             i_acc_en,
  input  logic                             i_acc_we,
  input  logic [$clog2(`APLIC_NR_DOM)-1:0] i_acc_dom,
  input  logic [`APLIC_ADDR_W-1:0]         i_acc_addr,
  input  logic [31:0]                      i_acc_wdata,
  output logic [31:0]                      o_acc_rdata,
  output logic [`APLIC_NR_SRC-1:0]         o_setip,
  output logic [`APLIC_NR_SRC-1:0]         o_setie,
  output logic [`APLIC_NR_SRC-1:0]         o_active,
  output logic [`APLIC_NR_SRC-1:0]         o_intp_domain,
  output logic [`APLIC_NR_DOM-1:0]         o_domaincfg_ie,
  output logic [`APLIC_NR_DOM-1:0]         o_domaincfg_dm
);

  aplic_wr_if wr ();

  logic [31:0] dom_rdata;
  logic [31:0] pend_rdata;
  logic [31:0] en_rdata;
  logic [31:0] tgt_rdata;

  aplic_reg_decode u_decode (
    .i_acc_en     (i_acc_en),
    .i_acc_we     (i_acc_we),
    .i_acc_dom    (i_acc_dom),
    .i_acc_addr   (i_acc_addr),
    .i_acc_wdata  (i_acc_wdata),
    .o_acc_rdata  (o_acc_rdata),
    .wr           (wr.decoder),
    .i_dom_rdata  (dom_rdata),
    .i_pend_rdata (pend_rdata),
    .i_en_rdata   (en_rdata),
    .i_tgt_rdata  (tgt_rdata)
  );

  aplic_domain_ctl u_domain (
    .i_clk          (i_clk),
    .ni_rst         (ni_rst),
    .wr             (wr.block),
    .o_rdata        (dom_rdata),
    .o_intp_domain  (o_intp_domain),
    .o_active       (o_active),
    .o_domaincfg_ie (o_domaincfg_ie),
    .o_domaincfg_dm (o_domaincfg_dm)
  );

  aplic_ix_bank #(.P_BANK(PENDING)) u_pend_bank (
    .i_clk         (i_clk),
    .ni_rst        (ni_rst),
    .wr            (wr.block),
    .i_intp_domain (o_intp_domain),
    .i_active      (o_active),
    .o_rdata       (pend_rdata),
    .o_bits        (o_setip)
  );

  aplic_ix_bank #(.P_BANK(ENABLE)) u_en_bank (
    .i_clk         (i_clk),
    .ni_rst        (ni_rst),
    .wr            (wr.block),
    .i_intp_domain (o_intp_domain),
    .i_active      (o_active),
    .o_rdata       (en_rdata),
    .o_bits        (o_setie)
  );

  aplic_target u_target (
    .i_clk         (i_clk),
    .ni_rst        (ni_rst),
    .wr            (wr.block),
    .i_intp_domain (o_intp_domain),
    .i_active      (o_active),
    .i_dm          (o_domaincfg_dm),
    .o_rdata       (tgt_rdata)
  );

endmodule

//--- test/aplic_regctl_checker.sv
/*
 * Checker for the APLIC register-control testbench. Compares read data with
 * the case expectations and checks the status outputs against them.
 */
`timescale 1ns/100ps
`include "aplic_cfg.svh"

module aplic_regctl_checker (
  input  logic                             i_clk,
  input  logic                             ni_rst,
  input  logic                             i_chk_en,
  input  logic [$clog2(`APLIC_NR_DOM)-1:0] i_chk_dom,
  input  logic [`APLIC_ADDR_W-1:0]         i_chk_addr,
  input  logic [31:0]                      i_chk_exp,
  input  logic [31:0]                      i_acc_rdata,
  input  logic [`APLIC_NR_SRC-1:0]         i_setip,
  input  logic [`APLIC_NR_SRC-1:0]         i_setie,
  input  logic [`APLIC_NR_SRC-1:0]         i_active,
  input  logic [`APLIC_NR_SRC-1:0]         i_intp_domain,
  input  logic [`APLIC_NR_DOM-1:0]         i_domaincfg_ie,
  input  logic [`APLIC_NR_DOM-1:0]         i_domaincfg_dm,
  output logic [31:0]                      o_data_errs,
  output logic [31:0]                      o_stat_errs
);

  int                      data_errs = 0;
  int                      stat_errs = 0;
  logic                    rst_seen  = 1'b0;
  logic [`APLIC_SRC_W-1:0] src;
  logic                    is_srccfg;

  // Word-aligned sourcecfg slot other than slot 0
  assign src       = i_chk_addr[`APLIC_SRC_W+1:2];
  assign is_srccfg = (i_chk_addr[`APLIC_ADDR_W-1:`APLIC_SRC_W+2] == '0) &&
                     (src != '0) && (i_chk_addr[1:0] == 2'b00);

  assign o_data_errs = data_errs;
  assign o_stat_errs = stat_errs;

  task automatic check_bit(input string name, input logic exp, input logic got);
    if (got !== exp) begin
      $display("Fail %s expected %h got %h", name, exp, got);
      stat_errs++;
    end
  endtask

  task automatic require_zero(input string name, input logic [31:0] got);
    if (got !== 32'h0) begin
      $display("Fail %s expected %h got %h", name, 32'h0, got);
      stat_errs++;
    end
  endtask

  // Every bit shown by a bank read must also be set on the status vector
  task automatic check_shown_bits(input string name, input logic [31:0] shown,
                                  input logic [31:0] got);
    if ((got & shown) !== shown) begin
      $display("Fail %s expected bits %h set got %h", name, shown, got);
      stat_errs++;
    end
  endtask

  task automatic compare_read();
    if (i_acc_rdata !== i_chk_exp) begin
      $display("Fail o_acc_rdata expected %h got %h (domain %0d, offset %h)",
               i_chk_exp, i_acc_rdata, i_chk_dom, i_chk_addr);
      data_errs++;
    end
    // IE and DM of domaincfg also drive the status outputs
    if (i_chk_addr == '0) begin
      check_bit($sformatf("o_domaincfg_ie[%0d]", i_chk_dom), i_chk_exp[8],
                i_domaincfg_ie[i_chk_dom]);
      check_bit($sformatf("o_domaincfg_dm[%0d]", i_chk_dom), i_chk_exp[2],
                i_domaincfg_dm[i_chk_dom]);
    end else if (is_srccfg) begin
      if (i_chk_exp[2:0] != 3'd0) begin
        // Only the owner sees a live mode
        check_bit($sformatf("o_active[%0d]", src), 1'b1, i_active[src]);
        check_bit($sformatf("o_intp_domain[%0d]", src), i_chk_dom, i_intp_domain[src]);
      end else if (i_chk_exp[10] && i_chk_dom == '0) begin
        check_bit($sformatf("o_intp_domain[%0d]", src), 1'b1, i_intp_domain[src]);
      end
    end else if (i_chk_addr == 16'h1C00) begin
      // setip word
      check_shown_bits("o_setip", i_chk_exp, i_setip);
    end else if (i_chk_addr == 16'h1E00) begin
      // setie word
      check_shown_bits("o_setie", i_chk_exp, i_setie);
    end
  endtask

  // Compare mid-cycle on the falling edge
  always @(negedge i_clk) begin
    if (ni_rst && !rst_seen) begin
      rst_seen <= 1'b1;
      require_zero("o_setip", i_setip);
      require_zero("o_setie", i_setie);
      require_zero("o_active", i_active);
      require_zero("o_intp_domain", i_intp_domain);
      require_zero("o_domaincfg_ie", 32'(i_domaincfg_ie));
      require_zero("o_domaincfg_dm", 32'(i_domaincfg_dm));
    end
    if (ni_rst && i_chk_en) begin
      compare_read();
    end
  end

endmodule

//--- test/tb_aplic_regctl.sv
/*
 * Testbench for the APLIC register-control core. Loads the access cases,
 * drives one access per cycle and hands read expectations to the checker.
 */
`timescale 1ns/100ps
`include "aplic_cfg.svh"

module tb_aplic_regctl;

  localparam string CASE_FILE = "test/aplic_regctl_cases.txt";

  logic                             i_clk;
  logic                             ni_rst;
  logic                             acc_en;
  logic                             acc_we;
  logic [$clog2(`APLIC_NR_DOM)-1:0] acc_dom;
  logic [`APLIC_ADDR_W-1:0]         acc_addr;
  logic [31:0]                      acc_wdata;
  logic [31:0]                      acc_rdata;
  logic [`APLIC_NR_SRC-1:0]         setip;
  logic [`APLIC_NR_SRC-1:0]         setie;
  logic [`APLIC_NR_SRC-1:0]         active;
  logic [`APLIC_NR_SRC-1:0]         intp_domain;
  logic [`APLIC_NR_DOM-1:0]         domaincfg_ie;
  logic [`APLIC_NR_DOM-1:0]         domaincfg_dm;

  // Read expectation, travels with the access it belongs to
  logic                             chk_en;
  logic [$clog2(`APLIC_NR_DOM)-1:0] chk_dom;
  logic [`APLIC_ADDR_W-1:0]         chk_addr;
  logic [31:0]                      chk_exp;

  logic [7:0]  case_op   [$];
  logic [31:0] case_dom  [$];
  logic [31:0] case_addr [$];
  logic [31:0] case_data [$];
  logic [31:0] case_exp  [$];

  int          setup_errs;
  int unsigned cycle_limit;
  logic        limit_ready = 1'b0;
  logic [31:0] data_errs;
  logic [31:0] stat_errs;

  always #4 i_clk = ~i_clk;

  aplic_regctl_top dut0 (
    .i_clk          (i_clk),
    .ni_rst         (ni_rst),
    .i_acc_en       (acc_en),
    .i_acc_we       (acc_we),
    .i_acc_dom      (acc_dom),
    .i_acc_addr     (acc_addr),
    .i_acc_wdata    (acc_wdata),
    .o_acc_rdata    (acc_rdata),
    .o_setip        (setip),
    .o_setie        (setie),
    .o_active       (active),
    .o_intp_domain  (intp_domain),
    .o_domaincfg_ie (domaincfg_ie),
    .o_domaincfg_dm (domaincfg_dm)
  );

  aplic_regctl_checker u_checker (
    .i_clk          (i_clk),
    .ni_rst         (ni_rst),
    .i_chk_en       (chk_en),
    .i_chk_dom      (chk_dom),
    .i_chk_addr     (chk_addr),
    .i_chk_exp      (chk_exp),
    .i_acc_rdata    (acc_rdata),
    .i_setip        (setip),
    .i_setie        (setie),
    .i_active       (active),
    .i_intp_domain  (intp_domain),
    .i_domaincfg_ie (domaincfg_ie),
    .i_domaincfg_dm (domaincfg_dm),
    .o_data_errs    (data_errs),
    .o_stat_errs    (stat_errs)
  );

  // ==========================================================================
  // Case file reader
  // ==========================================================================
  // Lines starting with # are column notes
  task automatic read_cases(input int fd);
    logic [7:0]  op;
    logic [31:0] dom;
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] exp;
    string       rest;
    int          code;
    logic        done;
    done = 1'b0;
    while (!done) begin
      code = $fscanf(fd, " %c", op);
      if (code != 1) begin
        done = 1'b1;
      end else if (op == "#") begin
        code = $fgets(rest, fd);
      end else begin
        code = $fscanf(fd, " %h %h %h %h", dom, addr, data, exp);
        if (code == 4 && (op == "W" || op == "R")) begin
          case_op.push_back(op);
          case_dom.push_back(dom);
          case_addr.push_back(addr);
          case_data.push_back(data);
          case_exp.push_back(exp);
        end else begin
          $display("Case %0d in the case file is malformed", case_op.size());
          setup_errs++;
          done = 1'b1;
        end
      end
    end
  endtask

  task automatic drive_case(input int n);
    acc_en    <= 1'b1;
    acc_we    <= (case_op[n] == "W");
    acc_dom   <= case_dom[n][$clog2(`APLIC_NR_DOM)-1:0];
    acc_addr  <= case_addr[n][`APLIC_ADDR_W-1:0];
    acc_wdata <= case_data[n];
    chk_en    <= (case_op[n] == "R");
    chk_dom   <= case_dom[n][$clog2(`APLIC_NR_DOM)-1:0];
    chk_addr  <= case_addr[n][`APLIC_ADDR_W-1:0];
    chk_exp   <= case_exp[n];
  endtask

  // ==========================================================================
  // Stimulus
  // ==========================================================================
  initial begin : main
    int fd;
    setup_errs  = 0;
    cycle_limit = 0;
    i_clk       = 1'b0;
    ni_rst      = 1'b0;
    acc_en      = 1'b0;
    acc_we      = 1'b0;
    acc_dom     = '0;
    acc_addr    = '0;
    acc_wdata   = '0;
    chk_en      = 1'b0;
    chk_dom     = '0;
    chk_addr    = '0;
    chk_exp     = '0;

    fd = $fopen(CASE_FILE, "r");
    if (fd == 0) begin
      $display("Cannot open the case file %s", CASE_FILE);
      setup_errs++;
    end else begin
      read_cases(fd);
      $fclose(fd);
    end
    if (case_op.size() == 0) begin
      $display("No access cases were loaded");
      setup_errs++;
    end

    // Two cycles per case plus reset and drain margin
    cycle_limit = 2 * case_op.size() + 20;
    limit_ready = 1'b1;

    repeat (3) @(posedge i_clk);
    ni_rst <= 1'b1;

    for (int i = 0; i < case_op.size(); i++) begin
      @(posedge i_clk);
      drive_case(i);
    end
    @(posedge i_clk);
    acc_en <= 1'b0;
    acc_we <= 1'b0;
    chk_en <= 1'b0;
    repeat (2) @(posedge i_clk);

    $display("Errors: read data %0d, status %0d, setup %0d",
             data_errs, stat_errs, setup_errs);
    if (data_errs == 0 && stat_errs == 0 && setup_errs == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    int unsigned cycles;
    cycles = 0;
    wait (limit_ready);
    while (cycles < cycle_limit) begin
      @(posedge i_clk);
      cycles++;
    end
    $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
    $display("TB FAILED");
    $finish;
  end

endmodule

//--- test/aplic_regctl_cases.txt
# op dom offset wdata expected, numbers in hex
# W writes wdata and ignores expected, R compares the read word with expected
R 0 0000 00000000 80000000
R 1 0000 00000000 80000000
W 0 0000 ffffffff 00000000
R 0 0000 00000000 80000104
W 0 0000 00000100 00000000
R 0 0000 00000000 80000100
W 0 000c 00000004 00000000
R 0 000c 00000000 00000004
W 0 0010 00000002 00000000
R 0 0010 00000000 00000000
W 0 0014 00000400 00000000
R 0 0014 00000000 00000400
W 1 0014 00000006 00000000
R 1 0014 00000000 00000006
W 1 000c 00000005 00000000
R 0 000c 00000000 00000004
R 1 000c 00000000 00000000
W 0 1cdc 00000003 00000000
R 0 1c00 00000000 00000008
W 0 1ddc 00000003 00000000
R 0 1c00 00000000 00000000
W 0 1c00 ffffffff 00000000
R 0 1c00 00000000 00000008
R 1 1c00 00000000 00000000
W 1 1cdc 00000005 00000000
R 1 1c00 00000000 00000020
R 0 1c00 00000000 00000008
W 0 1d00 ffffffff 00000000
R 0 1d00 00000000 00000000
R 0 1c00 00000000 00000000
R 1 1c00 00000000 00000020
W 0 1edc 00000003 00000000
R 0 1e00 00000000 00000008
W 0 1fdc 00000003 00000000
R 0 1e00 00000000 00000000
W 0 1e00 ffffffff 00000000
R 0 1e00 00000000 00000008
R 1 1e00 00000000 00000000
W 0 1f00 00000008 00000000
R 0 1e00 00000000 00000000
W 0 1e00 ffffffff 00000000
W 0 000c 00000000 00000000
R 0 000c 00000000 00000000
R 0 1e00 00000000 00000000
W 0 000c 00000004 00000000
W 0 300c ffffff00 00000000
R 0 300c 00000000 fffc0001
W 0 3010 ffffff00 00000000
R 0 3010 00000000 00000000
W 1 0000 00000004 00000000
R 1 0000 00000000 80000004
W 1 3014 ffffffff 00000000
R 1 3014 00000000 fffff7ff
R 0 3014 00000000 00000000

//--- files.f
+incdir+logic
logic/aplic_map_pkg.sv
logic/aplic_intr_pkg.sv
logic/aplic_wr_if.sv
logic/aplic_reg_decode.sv
logic/aplic_domain_ctl.sv
logic/aplic_ix_bank.sv
logic/aplic_target.sv
logic/aplic_regctl_top.sv
test/aplic_regctl_checker.sv
test/tb_aplic_regctl.sv

//--- run_sim.sh
#!/bin/sh
# Builds the APLIC register-control testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --timescale 1ns/100ps -f files.f \
  --top-module tb_aplic_regctl -o sim_aplic
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_aplic > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q "^TB PASSED$" "$LOG"; then
  exit 0
fi
echo "Pass message not found in $LOG"
exit 1
